/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // datapath width, shared by registers and addresses
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // one word below the boot vector
    // so the first fetch goes to 0x1c000000
    localparam word_t reset_pc = 32'h1bff_fffc;

    // alu operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_t;

    // control-transfer kinds
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_b    = 3'd1,
        br_bl   = 3'd2,
        br_beq  = 3'd3,
        br_bne  = 3'd4,
        br_jirl = 3'd5
    } br_kind_t;

    // IF -> ID
    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    // ID -> EX
    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        br_kind_t  br_kind;
        logic      src1_is_pc;
        logic      src2_is_imm;
        word_t     imm;
        // b/bl or beq/bne/jirl offset, already chosen
        word_t     br_offs;
        word_t     rj_value;
        word_t     rkd_value;
        logic      gr_we;
        reg_addr_t dest;
    } id_ex_t;

    // EX -> WB
    typedef struct packed {
        word_t     pc;
        logic      gr_we;
        reg_addr_t dest;
        word_t     result;
    } ex_wb_t;

endpackage

/* hdl/rf_read_if.sv */
interface rf_read_if;

    // two read ports, rj and rk/rd
    cpu_pkg::reg_addr_t raddr1;
    cpu_pkg::reg_addr_t raddr2;
    cpu_pkg::word_t     rdata1;
    cpu_pkg::word_t     rdata2;

    // decode side
    modport reader (
        output raddr1,
        output raddr2,
        input  rdata1,
        input  rdata2
    );

    // register file side, data combinational from the addresses
    modport rf (
        input  raddr1,
        input  raddr2,
        output rdata1,
        output rdata2
    );

endinterface

/* hdl/fetch_unit.sv */
module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            redirect_valid,
    input  cpu_pkg::word_t  redirect_target,
    input  cpu_pkg::word_t  inst_sram_rdata,
    output cpu_pkg::word_t  inst_sram_addr,
    output logic            if_valid,
    output cpu_pkg::if_id_t if_data
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t next_pc;

    // taken branch in EX wins over sequential fetch
    assign next_pc = redirect_valid ? redirect_target : pc + 32'd4;

    // sram is addressed with the next pc, word comes back one cycle later
    assign inst_sram_addr = next_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= cpu_pkg::reset_pc;
            if_valid <= 1'b0;
        end else begin
            pc       <= next_pc;
            // first cycle after reset has no word yet
            if_valid <= 1'b1;
        end
    end

    // returned word lines up with the current pc
    assign if_data.pc   = pc;
    assign if_data.inst = inst_sram_rdata;

endmodule

/* hdl/decode_unit.sv */
module decode_unit (
    input  cpu_pkg::if_id_t id_data,
    rf_read_if.reader       rd_port,
    output cpu_pkg::id_ex_t ex_data
);

    cpu_pkg::word_t     inst;
    logic [5:0]         op_31_26;
    logic [3:0]         op_25_22;
    logic [1:0]         op_21_20;
    logic [4:0]         op_19_15;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::reg_addr_t rj;
    cpu_pkg::reg_addr_t rk;
    logic [11:0]        i12;
    logic [19:0]        i20;
    logic [15:0]        i16;
    logic [25:0]        i26;
    logic               op_3r;
    logic               op_shift;
    logic               inst_add_w;
    logic               inst_sub_w;
    logic               inst_slt;
    logic               inst_sltu;
    logic               inst_nor;
    logic               inst_and;
    logic               inst_or;
    logic               inst_xor;
    logic               inst_slli_w;
    logic               inst_srli_w;
    logic               inst_srai_w;
    logic               inst_addi_w;
    logic               inst_lu12i_w;
    logic               inst_jirl;
    logic               inst_b;
    logic               inst_bl;
    logic               inst_beq;
    logic               inst_bne;
    logic               is_link;
    cpu_pkg::alu_op_t   alu_op;
    cpu_pkg::br_kind_t  br_kind;

    assign inst     = id_data.inst;
    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    // 26-bit offset is split with its high part in the rd/rj bits
    assign i26      = {inst[9:0], inst[25:10]};

    // 3R group and immediate shift group share the upper fields
    assign op_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign op_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = op_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = op_3r && (op_19_15 == 5'h02);
    assign inst_slt     = op_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = op_3r && (op_19_15 == 5'h05);
    assign inst_nor     = op_3r && (op_19_15 == 5'h08);
    assign inst_and     = op_3r && (op_19_15 == 5'h09);
    assign inst_or      = op_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = op_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = op_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = op_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = op_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);

    // link instructions compute pc + 4 through the alu
    assign is_link = inst_jirl || inst_bl;

    // add by default for add.w, addi.w and the links
    always_comb begin
        alu_op = cpu_pkg::alu_add;
        if (inst_sub_w)
            alu_op = cpu_pkg::alu_sub;
        else if (inst_slt)
            alu_op = cpu_pkg::alu_slt;
        else if (inst_sltu)
            alu_op = cpu_pkg::alu_sltu;
        else if (inst_and)
            alu_op = cpu_pkg::alu_and;
        else if (inst_nor)
            alu_op = cpu_pkg::alu_nor;
        else if (inst_or)
            alu_op = cpu_pkg::alu_or;
        else if (inst_xor)
            alu_op = cpu_pkg::alu_xor;
        else if (inst_slli_w)
            alu_op = cpu_pkg::alu_sll;
        else if (inst_srli_w)
            alu_op = cpu_pkg::alu_srl;
        else if (inst_srai_w)
            alu_op = cpu_pkg::alu_sra;
        else if (inst_lu12i_w)
            alu_op = cpu_pkg::alu_lui;
    end

    always_comb begin
        br_kind = cpu_pkg::br_none;
        if (inst_b)
            br_kind = cpu_pkg::br_b;
        else if (inst_bl)
            br_kind = cpu_pkg::br_bl;
        else if (inst_beq)
            br_kind = cpu_pkg::br_beq;
        else if (inst_bne)
            br_kind = cpu_pkg::br_bne;
        else if (inst_jirl)
            br_kind = cpu_pkg::br_jirl;
    end

    // beq/bne compare rj against rd
    assign rd_port.raddr1 = rj;
    assign rd_port.raddr2 = (inst_beq || inst_bne) ? rd : rk;

    assign ex_data.pc          = id_data.pc;
    assign ex_data.alu_op      = alu_op;
    assign ex_data.br_kind     = br_kind;
    assign ex_data.src1_is_pc  = is_link;
    assign ex_data.src2_is_imm = op_shift || inst_addi_w || inst_lu12i_w || is_link;
    // shift amount is the low 5 bits of the sign-extended i12
    assign ex_data.imm = is_link      ? 32'd4 :
                         inst_lu12i_w ? {i20, 12'b0} :
                                        {{20{i12[11]}}, i12};
    assign ex_data.br_offs = (inst_b || inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                                   {{14{i16[15]}}, i16, 2'b0};
    assign ex_data.rj_value  = rd_port.rdata1;
    assign ex_data.rkd_value = rd_port.rdata2;
    // unknown words write nothing
    assign ex_data.gr_we = inst_add_w || inst_sub_w || inst_slt || inst_sltu ||
                           inst_nor || inst_and || inst_or || inst_xor ||
                           inst_slli_w || inst_srli_w || inst_srai_w ||
                           inst_addi_w || inst_lu12i_w || is_link;
    assign ex_data.dest  = inst_bl ? 5'd1 : rd;

endmodule

/* hdl/regfile.sv */
module regfile (
    input  logic            clk,
    rf_read_if.rf           rd_port,
    input  logic            wb_valid,
    input  cpu_pkg::ex_wb_t wb_data,
    output logic            commit_we
);

    cpu_pkg::word_t regs [32];
    logic           fwd1;
    logic           fwd2;

    // commit strobe also drives the trace, r0 writes included
    assign commit_we = wb_valid && wb_data.gr_we;

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (commit_we && (wb_data.dest != 5'd0)) begin
            regs[wb_data.dest] <= wb_data.result;
        end
    end

    // same-cycle write is visible to the reader
    assign fwd1 = commit_we && (wb_data.dest == rd_port.raddr1);
    assign fwd2 = commit_we && (wb_data.dest == rd_port.raddr2);

    assign rd_port.rdata1 = (rd_port.raddr1 == 5'd0) ? 32'd0 :
                            fwd1                     ? wb_data.result :
                                                       regs[rd_port.raddr1];
    assign rd_port.rdata2 = (rd_port.raddr2 == 5'd0) ? 32'd0 :
                            fwd2                     ? wb_data.result :
                                                       regs[rd_port.raddr2];

endmodule

/* hdl/stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_allowin,
    input  logic     in_allowin,
    output logic     out_valid,
    output payload_t out_data
);

    logic ready_go;

    // no stage ever waits
    assign ready_go = out_valid;

    // empty, or the held entry moves on this cycle
    assign out_allowin = !out_valid || (ready_go && in_allowin);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (out_allowin) begin
            out_valid <= in_valid;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (in_valid && out_allowin) begin
            out_data <= in_data;
        end
    end

endmodule

/* hdl/alu.sv */
module alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::word_t   src1,
    input  cpu_pkg::word_t   src2,
    output cpu_pkg::word_t   result
);

    logic [4:0] shamt;

    // shift amount from the low bits only
    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add:
                result = src1 + src2;
            cpu_pkg::alu_sub:
                result = src1 - src2;
            cpu_pkg::alu_slt:
                result = {31'd0, $signed(src1) < $signed(src2)};
            cpu_pkg::alu_sltu:
                result = {31'd0, src1 < src2};
            cpu_pkg::alu_and:
                result = src1 & src2;
            cpu_pkg::alu_nor:
                result = ~(src1 | src2);
            cpu_pkg::alu_or:
                result = src1 | src2;
            cpu_pkg::alu_xor:
                result = src1 ^ src2;
            cpu_pkg::alu_sll:
                result = src1 << shamt;
            cpu_pkg::alu_srl:
                result = src1 >> shamt;
            // arithmetic, keeps the sign
            cpu_pkg::alu_sra:
                result = $signed(src1) >>> shamt;
            // upper immediate is already formed in decode
            cpu_pkg::alu_lui:
                result = src2;
            default:
                result = 32'd0;
        endcase
    end

endmodule

/* hdl/branch_unit.sv */
module branch_unit (
    input  cpu_pkg::br_kind_t br_kind,
    input  cpu_pkg::word_t    pc,
    input  cpu_pkg::word_t    rj_value,
    input  cpu_pkg::word_t    rkd_value,
    input  cpu_pkg::word_t    br_offs,
    output logic              taken,
    output cpu_pkg::word_t    target
);

    logic rj_eq_rd;

    // rkd holds rd for beq/bne
    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        case (br_kind)
            cpu_pkg::br_b, cpu_pkg::br_bl, cpu_pkg::br_jirl:
                taken = 1'b1;
            cpu_pkg::br_beq:
                taken = rj_eq_rd;
            cpu_pkg::br_bne:
                taken = !rj_eq_rd;
            default:
                taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target = ((br_kind == cpu_pkg::br_jirl) ? rj_value : pc) + br_offs;

endmodule

/* hdl/exec_stage.sv */
module exec_stage (
    input  logic            ex_valid,
    input  cpu_pkg::id_ex_t ex_data,
    output cpu_pkg::ex_wb_t wb_data,
    output logic            redirect_valid,
    output cpu_pkg::word_t  redirect_target
);

    cpu_pkg::word_t alu_src1;
    cpu_pkg::word_t alu_src2;
    cpu_pkg::word_t alu_result;
    logic           br_taken;

    // pc as src1 only for the links
    assign alu_src1 = ex_data.src1_is_pc ? ex_data.pc : ex_data.rj_value;
    assign alu_src2 = ex_data.src2_is_imm ? ex_data.imm : ex_data.rkd_value;

    alu u_alu (
        .alu_op (ex_data.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // runs beside the alu
    branch_unit u_branch_unit (
        .br_kind   (ex_data.br_kind),
        .pc        (ex_data.pc),
        .rj_value  (ex_data.rj_value),
        .rkd_value (ex_data.rkd_value),
        .br_offs   (ex_data.br_offs),
        .taken     (br_taken),
        .target    (redirect_target)
    );

    // a bubble in EX must not redirect
    assign redirect_valid = ex_valid && br_taken;

    assign wb_data.pc     = ex_data.pc;
    assign wb_data.gr_we  = ex_data.gr_we;
    assign wb_data.dest   = ex_data.dest;
    assign wb_data.result = alu_result;

endmodule

/* hdl/cpu_top.sv */
module cpu_top (
    input  logic               clk,
    input  logic               reset,
    output logic               inst_sram_en,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic               debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    logic            redirect_valid;
    cpu_pkg::word_t  redirect_target;
    logic            if_valid;
    cpu_pkg::if_id_t if_data;
    logic            id_valid;
    cpu_pkg::if_id_t id_data;
    cpu_pkg::id_ex_t dec_data;
    logic            id_ex_allowin;
    logic            ex_valid;
    cpu_pkg::id_ex_t ex_data;
    cpu_pkg::ex_wb_t ex_result;
    logic            ex_wb_allowin;
    logic            wb_valid;
    cpu_pkg::ex_wb_t wb_data;
    logic            commit_we;

    rf_read_if rf_rd ();

    // sram always selected
    assign inst_sram_en = 1'b1;

    fetch_unit u_fetch_unit (
        .clk             (clk),
        .reset           (reset),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .inst_sram_rdata (inst_sram_rdata),
        .inst_sram_addr  (inst_sram_addr),
        .if_valid        (if_valid),
        .if_data         (if_data)
    );

    // fetch never stalls, so its allowin is left open
    stage_reg #(.payload_t(cpu_pkg::if_id_t)) if_id_reg (
        .clk         (clk),
        .reset       (reset),
        .flush       (redirect_valid),
        .in_valid    (if_valid),
        .in_data     (if_data),
        .out_allowin (),
        .in_allowin  (id_ex_allowin),
        .out_valid   (id_valid),
        .out_data    (id_data)
    );

    decode_unit u_decode_unit (
        .id_data (id_data),
        .rd_port (rf_rd.reader),
        .ex_data (dec_data)
    );

    stage_reg #(.payload_t(cpu_pkg::id_ex_t)) id_ex_reg (
        .clk         (clk),
        .reset       (reset),
        .flush       (redirect_valid),
        .in_valid    (id_valid),
        .in_data     (dec_data),
        .out_allowin (id_ex_allowin),
        .in_allowin  (ex_wb_allowin),
        .out_valid   (ex_valid),
        .out_data    (ex_data)
    );

    exec_stage u_exec_stage (
        .ex_valid        (ex_valid),
        .ex_data         (ex_data),
        .wb_data         (ex_result),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target)
    );

    // WB always drains, branch sits here when it redirects
    stage_reg #(.payload_t(cpu_pkg::ex_wb_t)) ex_wb_reg (
        .clk         (clk),
        .reset       (reset),
        .flush       (1'b0),
        .in_valid    (ex_valid),
        .in_data     (ex_result),
        .out_allowin (ex_wb_allowin),
        .in_allowin  (1'b1),
        .out_valid   (wb_valid),
        .out_data    (wb_data)
    );

    regfile u_regfile (
        .clk       (clk),
        .rd_port   (rf_rd.rf),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data),
        .commit_we (commit_we)
    );

    // commit trace
    assign debug_wb_pc       = wb_data.pc;
    assign debug_wb_rf_we    = commit_we;
    assign debug_wb_rf_wnum  = wb_data.dest;
    assign debug_wb_rf_wdata = wb_data.result;

endmodule

/* test/tb_cpu_top.sv */
module tb_cpu_top;

    // boot vector and unloaded-word value of the instruction memory
    localparam cpu_pkg::word_t boot_pc  = 32'h1c00_0000;
    localparam cpu_pkg::word_t nop_word = 32'h0340_0000;
    localparam int             imem_depth = 64;
    localparam int             max_exp    = 64;

    logic               clk;
    logic               reset;
    logic               inst_sram_en;
    cpu_pkg::word_t     inst_sram_addr;
    cpu_pkg::word_t     inst_sram_rdata;
    cpu_pkg::word_t     debug_wb_pc;
    logic               debug_wb_rf_we;
    cpu_pkg::reg_addr_t debug_wb_rf_wnum;
    cpu_pkg::word_t     debug_wb_rf_wdata;

    // program image and expected commit trace
    cpu_pkg::word_t     imem [imem_depth];
    cpu_pkg::word_t     exp_pc [max_exp];
    cpu_pkg::reg_addr_t exp_wnum [max_exp];
    cpu_pkg::word_t     exp_wdata [max_exp];
    int                 n_exp = 0;
    int                 n_words = 0;
    int                 exp_idx = 0;
    int                 cycles = 0;
    int                 limit = 0;
    cpu_pkg::word_t     fetch_addr;

    // file parsing
    int                 fd;
    int                 code;
    logic [7:0]         tag;
    logic [8*160-1:0]   skip_line;
    cpu_pkg::word_t     load_addr;
    cpu_pkg::word_t     load_word;

    cpu_top dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #20 clk = ~clk;

    task automatic fail_and_stop;
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, expected);
            fail_and_stop();
        end
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, expected);
            fail_and_stop();
        end
    endtask

    task automatic check_reg_num(input string name, input cpu_pkg::reg_addr_t got,
                                 input cpu_pkg::reg_addr_t expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, expected);
            fail_and_stop();
        end
    endtask

    // anything outside the loaded window reads as nop
    function automatic cpu_pkg::word_t read_word(input cpu_pkg::word_t addr);
        cpu_pkg::word_t offs;
        offs = addr - boot_pc;
        if (addr < boot_pc || (offs >> 2) >= imem_depth || addr[1:0] != 2'b00)
            return nop_word;
        return imem[offs >> 2];
    endfunction

    // sram model takes the address mid-cycle and returns the word after the next edge
    always @(negedge clk) begin
        fetch_addr = inst_sram_addr;
    end

    always @(posedge clk) begin
        #2;
        inst_sram_rdata = read_word(fetch_addr);
    end

    // reset behaviour and commit trace sampled on the falling edge
    always @(negedge clk) begin
        check_bit("inst_sram_en", inst_sram_en, 1'b1);
        if (reset || cycles == 0) begin
            check_bit("debug_wb_rf_we", debug_wb_rf_we, 1'b0);
            check_word("inst_sram_addr", inst_sram_addr, boot_pc);
        end else if (debug_wb_rf_we === 1'b1) begin
            if (exp_idx >= n_exp) begin
                $display("unexpected commit from pc %h at %0t", debug_wb_pc, $time);
                fail_and_stop();
            end
            check_word("debug_wb_pc", debug_wb_pc, exp_pc[exp_idx]);
            check_reg_num("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_wnum[exp_idx]);
            check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata[exp_idx]);
            exp_idx++;
        end else if (debug_wb_rf_we !== 1'b0) begin
            $display("trace write enable is unknown at %0t", $time);
            fail_and_stop();
        end
    end

    // run limit in cycles after reset
    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles >= limit) begin
                $display("timeout: commits did not finish, %0d of %0d seen in %0d cycles",
                         exp_idx, n_exp, cycles);
                fail_and_stop();
            end
        end
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        inst_sram_rdata = nop_word;
        fetch_addr      = boot_pc;
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = nop_word;
        end

        fd = $fopen("test/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/cpu_stimulus.txt");
            fail_and_stop();
        end
        // I lines load the program and E lines queue expected commits
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(skip_line, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %h", load_addr, load_word);
                if (code != 2) begin
                    $display("malformed program line in stimulus file");
                    fail_and_stop();
                end
                if (load_addr < boot_pc || ((load_addr - boot_pc) >> 2) >= imem_depth) begin
                    $display("program address %h outside instruction memory", load_addr);
                    fail_and_stop();
                end
                imem[(load_addr - boot_pc) >> 2] = load_word;
                n_words++;
            end else if (tag == "E") begin
                if (n_exp >= max_exp) begin
                    $display("too many expected commits in stimulus file");
                    fail_and_stop();
                end
                code = $fscanf(fd, "%h %h %h", exp_pc[n_exp], exp_wnum[n_exp],
                               exp_wdata[n_exp]);
                if (code != 3) begin
                    $display("malformed expected-commit line in stimulus file");
                    fail_and_stop();
                end
                n_exp++;
            end else begin
                $display("unknown line tag in stimulus file");
                fail_and_stop();
            end
        end
        $fclose(fd);
        if (n_exp == 0) begin
            $display("stimulus file holds no expected commits");
            fail_and_stop();
        end

        // four cycles per commit and per word plus slack
        limit = 4 * n_exp + 4 * n_words + 50;

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        wait (exp_idx == n_exp);
        // a few more cycles to catch stray commits
        repeat (8) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* build.f */
hdl/cpu_pkg.sv
hdl/rf_read_if.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/regfile.sv
hdl/stage_reg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/exec_stage.sv
hdl/cpu_top.sv
test/tb_cpu_top.sv

/* test/cpu_stimulus.txt */
# I <addr> <word> : program word at a byte address, all hex
# E <pc> <wnum> <wdata> : expected commit, in order, all hex
# alu block, producers two ahead of consumers
I 1c000000 02800c01
I 1c000004 02bfec02
I 1c000008 142468a4
I 1c00000c 00100823
I 1c000010 00110825
I 1c000014 00120446
I 1c000018 00128447
I 1c00001c 00140488
I 1c000020 00148889
I 1c000024 0015048a
I 1c000028 0015888b
I 1c00002c 0040904c
I 1c000030 0044904d
I 1c000034 0048844e
# b over two words, then bne not taken, then beq taken
I 1c000038 50000c00
I 1c00003c 029ffc0f
I 1c000040 02800410
I 1c000044 0280400f
I 1c000048 02804010
I 1c00004c 028005f1
I 1c000050 5c0021f0
I 1c000054 02800632
I 1c000058 58000df0
I 1c00005c 02815413
I 1c000060 02819814
# bl, jirl, write to r0, read of r0, self loop
I 1c000064 54001000
I 1c000068 02800415
I 1c00006c 02800416
I 1c000074 4c001838
I 1c000078 02800419
I 1c00007c 0280041a
I 1c000080 02848c00
I 1c000084 0280131b
I 1c000088 0010041c
I 1c00008c 50000000
# commit trace
E 1c000000 01 00000003
E 1c000004 02 fffffffb
E 1c000008 04 12345000
E 1c00000c 03 fffffffe
E 1c000010 05 00000008
E 1c000014 06 00000001
E 1c000018 07 00000000
E 1c00001c 08 edcbaffc
E 1c000020 09 12345000
E 1c000024 0a 12345003
E 1c000028 0b edcbaffb
E 1c00002c 0c ffffffb0
E 1c000030 0d 0fffffff
E 1c000034 0e fffffffd
E 1c000044 0f 00000010
E 1c000048 10 00000010
E 1c00004c 11 00000011
E 1c000054 12 00000012
E 1c000064 01 1c000068
E 1c000074 18 1c000078
E 1c000080 00 00000123
E 1c000084 1b 1c00007c
E 1c000088 1c 1c000068
